// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instruction bits 6:2

    // OP-IMM: addi, slli, srli, srai, andi
    localparam logic [4:0] RV32_OPC_ARI  = 5'b00100;

    // OP: add, sub, xor, or, and
    localparam logic [4:0] RV32_OPC_ARR  = 5'b01100;

    localparam logic [4:0] RV32_OPC_LD   = 5'b00000;
    localparam logic [4:0] RV32_OPC_STR  = 5'b01000;
    localparam logic [4:0] RV32_OPC_LUI  = 5'b01101;
    localparam logic [4:0] RV32_OPC_JAL  = 5'b11011;
    localparam logic [4:0] RV32_OPC_JALR = 5'b11001;

    // conditional branches
    localparam logic [4:0] RV32_OPC_B    = 5'b11000;

    // compressed quadrants, instruction bits 1:0
    // 2'b11 is not a quadrant, it marks a full 32-bit instruction
    localparam logic [1:0] RV32_C_Q0_DET = 2'b00;
    localparam logic [1:0] RV32_C_Q1_DET = 2'b01;
    localparam logic [1:0] RV32_C_Q2_DET = 2'b10;

endpackage

// File: hw/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // one 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // a fetched memory word, seen whole or as two parcels
    // parcels[0] holds the low half, which sits at the lower address
    typedef union packed {
        logic [31:0]      word;
        parcel_t [1:0]    parcels;
    } fetch_word_u;

endpackage

// File: hw/rv_parcel_queue.sv
`timescale 1ns/10ps

module rv_parcel_queue
    import rv_fetch_pkg::*;
#(
    parameter int          QUEUE_DEPTH = 8,
    parameter logic [31:0] RESET_PC    = 32'h0
)
(
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_wr,
    input  fetch_word_u                        i_wr_word,
    input  logic                               i_flush,
    input  logic [31:0]                        i_flush_pc,
    input  logic                               i_pop,
    input  logic                               i_pop_two,
    output logic [$clog2(QUEUE_DEPTH):0]       o_count,
    output parcel_t                            o_parcel0,
    output parcel_t                            o_parcel1,
    output logic [31:0]                        o_head_pc
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    parcel_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   rd_ptr_nxt;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   wr_ptr_nxt;
    logic [CNT_W-1:0]   count;
    logic [31:0]        head_pc;
    logic               skip_low;
    logic               do_wr;
    logic [1:0]         n_wr;
    logic [1:0]         n_pop;

    // a flush in the same cycle wins over the write
    assign do_wr      = i_wr && !i_flush;
    assign n_wr       = do_wr ? (skip_low ? 2'd1 : 2'd2) : 2'd0;
    assign n_pop      = i_pop ? (i_pop_two ? 2'd2 : 2'd1) : 2'd0;
    assign rd_ptr_nxt = rd_ptr + 1'b1;
    assign wr_ptr_nxt = wr_ptr + 1'b1;

    always_ff @(posedge i_clk)
    begin
        if (do_wr)
        begin
            if (skip_low)
            begin
                mem[wr_ptr] <= i_wr_word.parcels[1];
            end
            else
            begin
                mem[wr_ptr]     <= i_wr_word.parcels[0];
                mem[wr_ptr_nxt] <= i_wr_word.parcels[1];
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            head_pc  <= {RESET_PC[31:1], 1'b0};
            skip_low <= RESET_PC[1];
        end
        else if (i_flush)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            head_pc  <= {i_flush_pc[31:1], 1'b0};
            // target in the upper half of a word, so the low parcel is not ours
            skip_low <= i_flush_pc[1];
        end
        else
        begin
            wr_ptr  <= wr_ptr + PTR_W'(n_wr);
            rd_ptr  <= rd_ptr + PTR_W'(n_pop);
            count   <= count + CNT_W'(n_wr) - CNT_W'(n_pop);
            head_pc <= head_pc + {29'b0, n_pop, 1'b0};
            if (do_wr)
            begin
                skip_low <= 1'b0;
            end
        end
    end

    assign o_count   = count;
    assign o_parcel0 = mem[rd_ptr];
    assign o_parcel1 = mem[rd_ptr_nxt];
    assign o_head_pc = head_pc;

    // the source has no back-pressure, so it must never find the buffer full
    a_wr_room: assert property (@(posedge i_clk) disable iff (i_rst)
        do_wr |-> (QUEUE_DEPTH - count) >= 2);

    a_pop_count: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> count >= (i_pop_two ? 2 : 1));

    // strobes at most every second cycle
    a_wr_spacing: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wr |=> !i_wr);

endmodule

// File: hw/rv_decode_comp.sv
`timescale 1ns/10ps

module rv_decode_comp
    import rv_isa_pkg::*;
(
    input  logic [31:0]     i_instruction,
    output logic [31:0]     o_instruction,
    output logic            o_illegal_instruction
);

    logic [15:0] c;
    logic [31:0] instruction;
    logic        illegal_instruction;

    assign c = i_instruction[15:0];

    always_comb
    begin
        instruction         = i_instruction;
        illegal_instruction = 1'b0;
        case (i_instruction[1:0])
        RV32_C_Q0_DET:
        begin
            case (c[15:14])
            2'b00:
            begin
                // c.addi4spn: addi rd', x2, nzuimm
                instruction = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000,
                               2'b01, c[4:2], RV32_OPC_ARI, 2'b11};
            end
            2'b01:
            begin
                // c.lw
                instruction = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                               2'b01, c[4:2], RV32_OPC_LD, 2'b11};
            end
            2'b11:
            begin
                // c.sw
                instruction = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                               c[11:10], c[6], 2'b00, RV32_OPC_STR, 2'b11};
            end
            default:
            begin
                // reserved slot, passed through
                illegal_instruction = 1'b1;
            end
            endcase
        end
        RV32_C_Q1_DET:
        begin
            case (c[15:13])
            3'b000:
            begin
                // c.addi, c.nop
                instruction = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7],
                               RV32_OPC_ARI, 2'b11};
            end
            3'b001, 3'b101:
            begin
                // c.jal links to x1, c.j to x0
                instruction = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                               {9{c[12]}}, 4'b0, ~c[15], RV32_OPC_JAL, 2'b11};
            end
            3'b010:
            begin
                // c.li
                instruction = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7],
                               RV32_OPC_ARI, 2'b11};
            end
            3'b011:
            begin
                if (c[11:7] == 5'd2)
                begin
                    // c.addi16sp
                    instruction = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'd2, 3'b000,
                                   5'd2, RV32_OPC_ARI, 2'b11};
                end
                else
                begin
                    // c.lui
                    instruction = {{15{c[12]}}, c[6:2], c[11:7], RV32_OPC_LUI, 2'b11};
                end
            end
            3'b100:
            begin
                case (c[11:10])
                2'b00, 2'b01:
                begin
                    // c.srli, c.srai share the shift encoding, bit 10 picks arithmetic
                    instruction = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101,
                                   2'b01, c[9:7], RV32_OPC_ARI, 2'b11};
                end
                2'b10:
                begin
                    // c.andi
                    instruction = {{7{c[12]}}, c[6:2], 2'b01, c[9:7], 3'b111,
                                   2'b01, c[9:7], RV32_OPC_ARI, 2'b11};
                end
                default:
                begin
                    case (c[6:5])
                    2'b00:
                    begin
                        // c.sub
                        instruction = {7'b0100000, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                                       2'b01, c[9:7], RV32_OPC_ARR, 2'b11};
                    end
                    2'b01:
                    begin
                        // c.xor
                        instruction = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100,
                                       2'b01, c[9:7], RV32_OPC_ARR, 2'b11};
                    end
                    2'b10:
                    begin
                        // c.or
                        instruction = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110,
                                       2'b01, c[9:7], RV32_OPC_ARR, 2'b11};
                    end
                    default:
                    begin
                        // c.and
                        instruction = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111,
                                       2'b01, c[9:7], RV32_OPC_ARR, 2'b11};
                    end
                    endcase
                end
                endcase
            end
            default:
            begin
                // c.beqz, c.bnez; bit 13 becomes funct3 bit 0
                instruction = {{4{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7], 2'b00, c[13],
                               c[11:10], c[4:3], c[12], RV32_OPC_B, 2'b11};
            end
            endcase
        end
        RV32_C_Q2_DET:
        begin
            case (c[15:14])
            2'b00:
            begin
                // c.slli
                instruction = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], RV32_OPC_ARI, 2'b11};
            end
            2'b01:
            begin
                // c.lwsp
                instruction = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                               RV32_OPC_LD, 2'b11};
            end
            2'b10:
            begin
                if (!c[12])
                begin
                    if (|c[6:2])
                    begin
                        // c.mv
                        instruction = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], RV32_OPC_ARR, 2'b11};
                    end
                    else
                    begin
                        // c.jr
                        instruction = {12'b0, c[11:7], 3'b000, 5'd0, RV32_OPC_JALR, 2'b11};
                    end
                end
                else if (|c[6:2])
                begin
                    // c.add
                    instruction = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], RV32_OPC_ARR, 2'b11};
                end
                else if (c[11:7] == 5'd0)
                begin
                    // c.ebreak
                    instruction = 32'h0010_0073;
                end
                else
                begin
                    // c.jalr
                    instruction = {12'b0, c[11:7], 3'b000, 5'd1, RV32_OPC_JALR, 2'b11};
                end
            end
            default:
            begin
                // c.swsp
                instruction = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00,
                               RV32_OPC_STR, 2'b11};
            end
            endcase
        end
        default:
        begin
            // a full 32-bit instruction has nothing to expand
            illegal_instruction = 1'b1;
        end
        endcase
    end

    assign o_instruction         = instruction;
    assign o_illegal_instruction = illegal_instruction;

endmodule

// File: hw/rv_instr_align.sv
`timescale 1ns/10ps

module rv_instr_align
    import rv_isa_pkg::*;
    import rv_fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
)
(
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_flush,
    input  logic [$clog2(QUEUE_DEPTH):0]       i_count,
    input  parcel_t                            i_parcel0,
    input  parcel_t                            i_parcel1,
    input  logic [31:0]                        i_head_pc,
    output logic                               o_pop,
    output logic                               o_pop_two,
    output logic                               o_instr_valid,
    output logic [31:0]                        o_instr,
    output logic [31:0]                        o_instr_pc,
    output logic                               o_instr_compressed,
    output logic                               o_instr_illegal
);

    logic        is_comp;
    logic        issue;
    logic [31:0] expanded;
    logic        exp_illegal;

    // low bits 11 mark a 32-bit instruction and anything else is compressed
    assign is_comp = i_parcel0[1:0] inside {RV32_C_Q0_DET, RV32_C_Q1_DET, RV32_C_Q2_DET};

    // a 32-bit instruction waits until its upper half is in the queue
    assign issue     = (i_count != '0) && (is_comp || i_count >= 2);
    assign o_pop     = issue;
    assign o_pop_two = !is_comp;

    rv_decode_comp u_decode_comp
    (
        .i_instruction          ({16'b0, i_parcel0}),
        .o_instruction          (expanded),
        .o_illegal_instruction  (exp_illegal)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_instr_valid <= 1'b0;
        end
        else
        begin
            o_instr_valid <= issue;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (issue)
        begin
            o_instr            <= is_comp ? expanded : {i_parcel1, i_parcel0};
            o_instr_pc         <= i_head_pc;
            o_instr_compressed <= is_comp;
            o_instr_illegal    <= is_comp && exp_illegal;
        end
    end

    // the queue is empty after a flush and nothing may issue from it
    a_flush_kills: assert property (@(posedge i_clk) disable iff (i_rst)
        i_flush |=> !o_instr_valid && !o_pop);

endmodule

// File: hw/rv_fetch_top.sv
`timescale 1ns/10ps

module rv_fetch_top
    import rv_fetch_pkg::*;
#(
    parameter int          QUEUE_DEPTH = 8,
    parameter logic [31:0] RESET_PC    = 32'h0
)
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_fetch_valid,
    input  fetch_word_u     i_fetch_word,
    input  logic            i_flush,
    input  logic [31:0]     i_flush_pc,
    output logic            o_instr_valid,
    output logic [31:0]     o_instr,
    output logic [31:0]     o_instr_pc,
    output logic            o_instr_compressed,
    output logic            o_instr_illegal
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

    logic [CNT_W-1:0] count;
    parcel_t          parcel0;
    parcel_t          parcel1;
    logic [31:0]      head_pc;
    logic             pop;
    logic             pop_two;

    rv_parcel_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RESET_PC       (RESET_PC)
    ) u_queue (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_wr           (i_fetch_valid),
        .i_wr_word      (i_fetch_word),
        .i_flush        (i_flush),
        .i_flush_pc     (i_flush_pc),
        .i_pop          (pop),
        .i_pop_two      (pop_two),
        .o_count        (count),
        .o_parcel0      (parcel0),
        .o_parcel1      (parcel1),
        .o_head_pc      (head_pc)
    );

    rv_instr_align #(
        .QUEUE_DEPTH        (QUEUE_DEPTH)
    ) u_align (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_flush            (i_flush),
        .i_count            (count),
        .i_parcel0          (parcel0),
        .i_parcel1          (parcel1),
        .i_head_pc          (head_pc),
        .o_pop              (pop),
        .o_pop_two          (pop_two),
        .o_instr_valid      (o_instr_valid),
        .o_instr            (o_instr),
        .o_instr_pc         (o_instr_pc),
        .o_instr_compressed (o_instr_compressed),
        .o_instr_illegal    (o_instr_illegal)
    );

endmodule

// File: dv/rv_fetch_tb.sv
`timescale 1ns/10ps

module rv_fetch_tb
    import rv_isa_pkg::*;
    import rv_fetch_pkg::*;
;

    localparam int          QUEUE_DEPTH = 8;
    localparam logic [31:0] RESET_PC    = 32'h0000_0100;

    logic           i_clk;
    logic           i_rst;
    logic           i_fetch_valid;
    fetch_word_u    i_fetch_word;
    logic           i_flush;
    logic [31:0]    i_flush_pc;
    logic           o_instr_valid;
    logic [31:0]    o_instr;
    logic [31:0]    o_instr_pc;
    logic           o_instr_compressed;
    logic           o_instr_illegal;

    // program parcels still to be sent and the expected outputs in program order
    parcel_t        prog[$];
    logic [31:0]    exp_instr[$];
    logic [31:0]    exp_pc[$];
    logic           exp_comp[$];
    logic           exp_ill[$];

    logic           want_any;
    logic [31:0]    want_instr;
    logic [31:0]    want_pc;
    logic           want_comp;
    logic           want_ill;

    logic [31:0]    rng_state;
    logic [31:0]    model_pc;
    int             errors;
    int             checked;
    int             tests;
    logic           timed_out;

    rv_fetch_top #(
        .QUEUE_DEPTH        (QUEUE_DEPTH),
        .RESET_PC           (RESET_PC)
    ) i_rv_fetch_top (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_fetch_valid      (i_fetch_valid),
        .i_fetch_word       (i_fetch_word),
        .i_flush            (i_flush),
        .i_flush_pc         (i_flush_pc),
        .o_instr_valid      (o_instr_valid),
        .o_instr            (o_instr),
        .o_instr_pc         (o_instr_pc),
        .o_instr_compressed (o_instr_compressed),
        .o_instr_illegal    (o_instr_illegal)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic void refresh_head();
        want_any = (exp_instr.size() != 0);
        if (want_any)
        begin
            want_instr = exp_instr[0];
            want_pc    = exp_pc[0];
            want_comp  = exp_comp[0];
            want_ill   = exp_ill[0];
        end
    endfunction

    task automatic expect_instr(logic [31:0] instr, logic comp, logic ill);
        exp_instr.push_back(instr);
        exp_pc.push_back(model_pc);
        exp_comp.push_back(comp);
        exp_ill.push_back(ill);
        refresh_head();
        model_pc = model_pc + (comp ? 32'd2 : 32'd4);
    endtask

    task automatic add_c(parcel_t c, logic [31:0] expanded, logic ill);
        prog.push_back(c);
        expect_instr(expanded, 1'b1, ill);
    endtask

    task automatic add_w(logic [31:0] w);
        prog.push_back(w[15:0]);
        prog.push_back(w[31:16]);
        expect_instr(w, 1'b0, 1'b0);
    endtask

    task automatic gen_word();
        logic [31:0] w;
        w = lcg_next();
        // keep clear of the 48-bit length prefix
        w[4:0] = {1'b0, w[3:2], 2'b11};
        add_w(w);
    endtask

    // one random compressed instruction with its expected form built from its fields
    task automatic gen_comp();
        logic [31:0] r;
        logic [2:0]  a3;
        logic [2:0]  b3;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [5:0]  imm6;
        logic [7:0]  u8;
        logic [11:0] simm;
        logic [2:0]  f3;
        r    = lcg_next();
        a3   = r[10:8];
        b3   = r[13:11];
        rd   = r[18:14];
        rs2  = r[23:19] | 5'd1;
        imm6 = r[29:24];
        u8   = r[31:24] | 8'h10;
        simm = {{6{imm6[5]}}, imm6};
        f3   = (r[1:0] == 2'd0) ? 3'b000 : {1'b1, r[1], r[1] & r[0]};
        case ((lcg_next() >> 16) % 10)
        0: add_c({3'b000, u8[3:2], u8[7:4], u8[0], u8[1], a3, 2'b00},
                 enc_i({2'b0, u8, 2'b00}, 5'd2, 3'b000, {2'b01, a3}, RV32_OPC_ARI), 1'b0);
        1: add_c({3'b010, imm6[3:1], b3, imm6[0], imm6[4], a3, 2'b00},
                 enc_i({5'b0, imm6[4:0], 2'b00}, {2'b01, b3}, 3'b010, {2'b01, a3},
                       RV32_OPC_LD), 1'b0);
        2: add_c({3'b110, imm6[3:1], b3, imm6[0], imm6[4], a3, 2'b00},
                 enc_s({5'b0, imm6[4:0], 2'b00}, {2'b01, a3}, {2'b01, b3}, 3'b010,
                       RV32_OPC_STR), 1'b0);
        3: add_c({3'b000, imm6[5], rd, imm6[4:0], 2'b01},
                 enc_i(simm, rd, 3'b000, rd, RV32_OPC_ARI), 1'b0);
        4: add_c({3'b010, imm6[5], rd, imm6[4:0], 2'b01},
                 enc_i(simm, 5'd0, 3'b000, rd, RV32_OPC_ARI), 1'b0);
        5: add_c({3'b100, imm6[5], 2'b10, a3, imm6[4:0], 2'b01},
                 enc_i(simm, {2'b01, a3}, 3'b111, {2'b01, a3}, RV32_OPC_ARI), 1'b0);
        6: add_c({3'b100, 1'b0, 2'b11, a3, r[1:0], b3, 2'b01},
                 enc_r((r[1:0] == 2'd0) ? 7'h20 : 7'h00, {2'b01, b3}, {2'b01, a3}, f3,
                       {2'b01, a3}, RV32_OPC_ARR), 1'b0);
        7: add_c({3'b000, 1'b0, rd, rs2, 2'b10},
                 enc_i({7'b0, rs2}, rd, 3'b001, rd, RV32_OPC_ARI), 1'b0);
        8: add_c({3'b010, imm6[3], rd, imm6[2:0], imm6[5:4], 2'b10},
                 enc_i({4'b0, imm6, 2'b00}, 5'd2, 3'b010, rd, RV32_OPC_LD), 1'b0);
        default: add_c({3'b100, r[2], rd, rs2, 2'b10},
                       enc_r(7'h00, rs2, r[2] ? rd : 5'd0, 3'b000, rd, RV32_OPC_ARR), 1'b0);
        endcase
    endtask

    // the reserved quadrant 0 slot passes through unchanged
    task automatic gen_reserved();
        logic [31:0] r;
        parcel_t     c;
        r = lcg_next();
        c = {3'b100, r[31:21], 2'b00};
        add_c(c, {16'b0, c}, 1'b1);
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_instr.size() != 0 && n < 200)
        begin
            step();
            n++;
        end
        if (exp_instr.size() != 0)
        begin
            $display("timed out waiting for %0d instructions", exp_instr.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_prog();
        fetch_word_u w;
        // pad to a whole word with c.nop
        if (prog.size() % 2 != 0)
        begin
            add_c(16'h0001, 32'h0000_0013, 1'b0);
        end
        while (prog.size() != 0)
        begin
            w.word[15:0]  = prog.pop_front();
            w.word[31:16] = prog.pop_front();
            i_fetch_valid = 1'b1;
            i_fetch_word  = w;
            step();
            i_fetch_valid = 1'b0;
            step();
        end
        wait_drain();
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    // retire the scoreboard head; the assertions below still see the old head
    always @(posedge i_clk)
    begin
        if (!i_rst && o_instr_valid && exp_instr.size() != 0)
        begin
            void'(exp_instr.pop_front());
            void'(exp_pc.pop_front());
            void'(exp_comp.pop_front());
            void'(exp_ill.pop_front());
            checked++;
            refresh_head();
        end
    end

    a_expected: assert property (@(posedge i_clk) disable iff (i_rst)
        o_instr_valid |-> want_any)
        else
        begin
            errors++;
            $display("an instruction came out when none was expected, pc %h",
                     $sampled(o_instr_pc));
        end

    a_instr: assert property (@(posedge i_clk) disable iff (i_rst)
        o_instr_valid && want_any |-> o_instr == want_instr)
        else
        begin
            errors++;
            $display("error o_instr expected %h got %h", $sampled(want_instr), $sampled(o_instr));
        end

    a_pc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_instr_valid && want_any |-> o_instr_pc == want_pc)
        else
        begin
            errors++;
            $display("error o_instr_pc expected %h got %h", $sampled(want_pc),
                     $sampled(o_instr_pc));
        end

    a_comp: assert property (@(posedge i_clk) disable iff (i_rst)
        o_instr_valid && want_any |-> o_instr_compressed == want_comp)
        else
        begin
            errors++;
            $display("error o_instr_compressed expected %h got %h", $sampled(want_comp),
                     $sampled(o_instr_compressed));
        end

    a_ill: assert property (@(posedge i_clk) disable iff (i_rst)
        o_instr_valid && want_any |-> o_instr_illegal == want_ill)
        else
        begin
            errors++;
            $display("error o_instr_illegal expected %h got %h", $sampled(want_ill),
                     $sampled(o_instr_illegal));
        end

    initial
    begin
        i_rst         = 1'b1;
        i_fetch_valid = 1'b0;
        i_fetch_word  = '0;
        i_flush       = 1'b0;
        i_flush_pc    = '0;
        rng_state     = 32'd64611;
        model_pc      = RESET_PC;
        errors        = 0;
        checked       = 0;
        tests         = 0;
        timed_out     = 1'b0;
        refresh_head();
        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        repeat (10) step();
        add_w(32'h0010_0093);
        run_prog();
        finish_test("reset and idle");

        if (!timed_out)
        begin
            repeat (16) gen_word();
            run_prog();
            finish_test("aligned 32-bit");
        end

        if (!timed_out)
        begin
            repeat (40) gen_comp();
            run_prog();
            finish_test("compressed");
        end

        if (!timed_out)
        begin
            // an odd compressed count first so that the next 32-bit one straddles
            gen_comp();
            gen_word();
            repeat (40)
            begin
                if (lcg_next() > 32'h8000_0000)
                begin
                    gen_word();
                end
                else
                begin
                    gen_comp();
                end
            end
            run_prog();
            finish_test("mixed straddle");
        end

        if (!timed_out)
        begin
            repeat (4) gen_reserved();
            run_prog();
            finish_test("reserved encoding");
        end

        if (!timed_out)
        begin
            // the flush in the next cycle kills this word before it comes out
            i_fetch_valid = 1'b1;
            i_fetch_word  = lcg_next();
            step();
            i_fetch_valid = 1'b0;
            i_flush       = 1'b1;
            i_flush_pc    = 32'h0000_2002 | ((lcg_next() >> 8) & 32'h0000_0ffc);
            model_pc      = i_flush_pc;
            step();
            i_flush = 1'b0;
            prog.push_back(parcel_t'(lcg_next()));
            repeat (9) gen_comp();
            gen_word();
            run_prog();
            finish_test("flush to upper half");
        end

        $display("tests %0d, instructions checked %0d, errors %0d", tests, checked, errors);
        if (timed_out || errors != 0)
        begin
            $display("STATUS: FAIL");
        end
        else
        begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

// File: rv_fetch_top.f
hw/rv_isa_pkg.sv
hw/rv_fetch_pkg.sv
hw/rv_parcel_queue.sv
hw/rv_decode_comp.sv
hw/rv_instr_align.sv
hw/rv_fetch_top.sv
dv/rv_fetch_tb.sv
